//--- rtl/conv_pkg.sv
// shared constants and types; kernel fixed at 3x3, 8-bit pixels and weights, 32-bit accumulation
package conv_pkg;

    // kernel geometry
    localparam int KER_DIM  = 3;
    localparam int KER_TAPS = KER_DIM * KER_DIM;

    localparam int PIX_W   = 8;
    localparam int WT_W    = 8;
    localparam int ACC_W   = 32;
    localparam int SHIFT_W = 5;
    localparam int PIX_MAX = (1 << PIX_W) - 1;  // clamp ceiling

    typedef logic [PIX_W-1:0]          pixel_t;
    typedef logic signed [WT_W-1:0]    weight_t;
    typedef logic signed [ACC_W-1:0]   acc_t;     // also holds the bias
    typedef logic [SHIFT_W-1:0]        shift_t;

    // one kernel row, index 0 is the left column
    typedef pixel_t  [KER_DIM-1:0]     pix_row_t;
    typedef weight_t [KER_DIM-1:0]     wt_row_t;

    // full window, row 0 is the upper row
    typedef pix_row_t [KER_DIM-1:0]    window_t;

    // all nine weights, row major
    typedef weight_t [KER_TAPS-1:0]    wt_set_t;

    // host register map
    localparam int CFG_ADDR_W = 4;
    localparam int CFG_DATA_W = 16;

    // addresses 0..8 hold the weights
    localparam logic [CFG_ADDR_W-1:0] REG_BIAS   = 4'd9;
    localparam logic [CFG_ADDR_W-1:0] REG_SHIFT  = 4'd10;
    localparam logic [CFG_ADDR_W-1:0] REG_FRAMES = 4'd11;  // read only

endpackage

//--- rtl/conv_cfg_if.sv
// kernel settings and frame status shared inside the engine; settings must stay static while busy
`timescale 1ns/100ps

interface conv_cfg_if import conv_pkg::*; ();

    wt_set_t weights;     // row major
    acc_t    bias;
    shift_t  shift;       // arithmetic right shift after the bias
    logic    busy;        // frame in flight
    logic    frame_done;  // one cycle, with the final result

    // register block side
    modport regs (
        output weights, bias, shift,
        input  busy, frame_done
    );

    // datapath reads the kernel
    modport mac (
        input weights, bias, shift
    );

    // window builder owns the frame status
    modport win (
        output busy, frame_done
    );

endinterface

//--- rtl/conv_cfg_regs.sv
// host register block; writes are single-cycle strobes, never while busy, reads are combinational
`timescale 1ns/100ps

module conv_cfg_regs import conv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  cfg_we_i,
    input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
    output logic [CFG_DATA_W-1:0] cfg_rdata_o,
    conv_cfg_if.regs              cfg
);

    wt_set_t               weights_q;
    acc_t                  bias_q;
    shift_t                shift_q;
    logic [CFG_DATA_W-1:0] frames_q;
    logic                  wt_sel;

    assign wt_sel = cfg_addr_i < CFG_ADDR_W'(KER_TAPS);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            weights_q <= '0;
            bias_q    <= '0;
            shift_q   <= '0;
            frames_q  <= '0;
        end else begin
            if (cfg_we_i) begin
                if (wt_sel) begin
                    weights_q[cfg_addr_i] <= $signed(cfg_wdata_i[WT_W-1:0]);  // low byte only
                end else if (cfg_addr_i == REG_BIAS) begin
                    bias_q <= acc_t'($signed(cfg_wdata_i));
                end else if (cfg_addr_i == REG_SHIFT) begin
                    shift_q <= cfg_wdata_i[SHIFT_W-1:0];
                end
            end
            if (cfg.frame_done) begin
                frames_q <= frames_q + 1'b1;  // wraps at 16 bits
            end
        end
    end

    // readback mux
    always_comb begin
        cfg_rdata_o = '0;
        if (wt_sel) begin
            cfg_rdata_o = CFG_DATA_W'($signed(weights_q[cfg_addr_i]));
        end else begin
            case (cfg_addr_i)
                REG_BIAS:   cfg_rdata_o = bias_q[CFG_DATA_W-1:0];  // came in as 16 bits
                REG_SHIFT:  cfg_rdata_o = CFG_DATA_W'(shift_q);
                REG_FRAMES: cfg_rdata_o = frames_q;
                default:    cfg_rdata_o = '0;
            endcase
        end
    end

    assign cfg.weights = weights_q;
    assign cfg.bias    = bias_q;
    assign cfg.shift   = shift_q;

    // kernel must not change under a frame in flight
    a_no_write_busy: assert property (
        @(posedge clk) disable iff (rst_i)
        cfg_we_i |-> !cfg.busy
    ) else $error("config write while a frame is in flight");

endmodule

//--- rtl/conv_window.sv
// raster window builder with zero halo; IMG_W >= 4, IMG_H >= 3, no pixel strobes during the drain
`timescale 1ns/100ps

module conv_window import conv_pkg::*; #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    pix_valid_i,
    input  pixel_t  pix_i,
    output window_t win_o,
    output logic    win_valid_o,
    output logic    win_last_o,
    conv_cfg_if.win cfg
);

    localparam int LAST_PIX = IMG_W * IMG_H - 1;
    localparam int LAST_K   = LAST_PIX + IMG_W + 1;  // final drain tick
    localparam int POS_W    = $clog2(LAST_K + 1);
    localparam int XW       = $clog2(IMG_W);
    localparam int YW       = $clog2(IMG_H);

    pixel_t lb_up1 [IMG_W];  // row above the incoming pixel
    pixel_t lb_up2 [IMG_W];  // two rows above
    window_t win_q;          // raw taps, column 2 is the newest

    logic [POS_W-1:0] pos_q;   // raster count k, runs on through the drain
    logic [XW-1:0]    in_x_q;  // column of the incoming sample
    logic [XW-1:0]    cx_q;    // centre of the next emitted window
    logic [YW-1:0]    cy_q;
    logic             draining_q;
    logic             busy_q;
    logic             last_d1_q;
    logic             done_q;
    logic             top_q, bot_q, lft_q, rgt_q;  // halo edges of the current window

    logic   step;
    logic   emit;
    logic   last_step;
    pixel_t pix_in;

    assign step      = pix_valid_i | draining_q;
    assign pix_in    = draining_q ? '0 : pix_i;  // zeros flush the lower rows
    assign emit      = step && (pos_q >= POS_W'(IMG_W + 1));
    assign last_step = draining_q && (pos_q == POS_W'(LAST_K));

    // line buffers and tap shift
    always_ff @(posedge clk) begin
        if (step) begin
            lb_up2[in_x_q] <= lb_up1[in_x_q];
            lb_up1[in_x_q] <= pix_in;
            for (int r = 0; r < KER_DIM; r++) begin
                for (int c = 0; c < KER_DIM - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
            end
            win_q[0][KER_DIM-1] <= lb_up2[in_x_q];
            win_q[1][KER_DIM-1] <= lb_up1[in_x_q];
            win_q[2][KER_DIM-1] <= pix_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pos_q       <= '0;
            in_x_q      <= '0;
            cx_q        <= '0;
            cy_q        <= '0;
            draining_q  <= 1'b0;
            busy_q      <= 1'b0;
            win_valid_o <= 1'b0;
            win_last_o  <= 1'b0;
            last_d1_q   <= 1'b0;
            done_q      <= 1'b0;
            top_q       <= 1'b0;
            bot_q       <= 1'b0;
            lft_q       <= 1'b0;
            rgt_q       <= 1'b0;
        end else begin
            win_valid_o <= emit;
            win_last_o  <= last_step;
            last_d1_q   <= win_last_o;  // lines up with the MAC stages
            done_q      <= last_d1_q;
            // stays up across a back-to-back next frame
            busy_q <= pix_valid_i | draining_q | (pos_q != '0) | (busy_q & ~done_q);

            if (emit) begin
                top_q <= cy_q == '0;
                bot_q <= cy_q == YW'(IMG_H - 1);
                lft_q <= cx_q == '0;
                rgt_q <= cx_q == XW'(IMG_W - 1);
                if (cx_q == XW'(IMG_W - 1)) begin
                    cx_q <= '0;
                    cy_q <= (cy_q == YW'(IMG_H - 1)) ? '0 : cy_q + 1'b1;
                end else begin
                    cx_q <= cx_q + 1'b1;
                end
            end

            if (last_step) begin
                pos_q      <= '0;
                in_x_q     <= '0;
                draining_q <= 1'b0;
            end else if (step) begin
                pos_q  <= pos_q + 1'b1;
                in_x_q <= (in_x_q == XW'(IMG_W - 1)) ? '0 : in_x_q + 1'b1;
                if (pix_valid_i && pos_q == POS_W'(LAST_PIX)) begin
                    draining_q <= 1'b1;  // last pixel, start the flush
                end
            end
        end
    end

    // halo, also hides the wrapped columns and stale lines
    always_comb begin
        for (int r = 0; r < KER_DIM; r++) begin
            for (int c = 0; c < KER_DIM; c++) begin
                win_o[r][c] = win_q[r][c];
                if ((r == 0 && top_q) || (r == KER_DIM - 1 && bot_q) ||
                    (c == 0 && lft_q) || (c == KER_DIM - 1 && rgt_q)) begin
                    win_o[r][c] = '0;
                end
            end
        end
    end

    assign cfg.busy       = busy_q;
    assign cfg.frame_done = done_q;

    a_no_pix_in_drain: assert property (
        @(posedge clk) disable iff (rst_i)
        draining_q |-> !pix_valid_i
    ) else $error("pixel strobe during frame drain");

    // centre counters wrap on the last window
    a_last_at_wrap: assert property (
        @(posedge clk) disable iff (rst_i)
        win_last_o |-> (cx_q == '0 && cy_q == '0)
    ) else $error("last window does not close the frame raster");

endmodule

//--- rtl/conv_row_pe.sv
// one kernel row; pixels are taken as unsigned, weights as signed, sum held until the next en_i
`timescale 1ns/100ps

module conv_row_pe import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     en_i,
    input  pix_row_t pix_i,
    input  wt_row_t  wt_i,
    output acc_t     sum_o
);

    acc_t prod [KER_DIM];
    acc_t row_sum;
    acc_t sum_q;

    // three taps, zero-extended pixel times signed weight
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < KER_DIM; c++) begin
            prod[c] = acc_t'($signed({1'b0, pix_i[c]})) * acc_t'($signed(wt_i[c]));
            row_sum = row_sum + prod[c];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sum_q <= '0;
        end else if (en_i) begin
            sum_q <= row_sum;
        end
    end

    assign sum_o = sum_q;

endmodule

//--- rtl/conv_mac_array.sv
// two-stage MAC; row products, then bias, arithmetic shift and clamp to 0..255
`timescale 1ns/100ps

module conv_mac_array import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  window_t win_i,
    input  logic    win_valid_i,
    input  logic    win_last_i,
    conv_cfg_if.mac cfg,
    output pixel_t  res_o,
    output logic    res_valid_o,
    output logic    res_last_o
);

    acc_t   row_sum [KER_DIM];
    acc_t   total;
    acc_t   scaled;
    pixel_t clamped;
    pixel_t res_q;
    logic   v1_q;
    logic   l1_q;

    // stage one, a PE per window row
    for (genvar r = 0; r < KER_DIM; r++) begin : g_row
        conv_row_pe u_row (
            .clk   (clk),
            .rst_i (rst_i),
            .en_i  (win_valid_i),
            .pix_i (win_i[r]),
            .wt_i  (cfg.weights[r*KER_DIM +: KER_DIM]),
            .sum_o (row_sum[r])
        );
    end

    // stage two arithmetic
    always_comb begin
        total = cfg.bias;
        for (int r = 0; r < KER_DIM; r++) begin
            total = total + row_sum[r];
        end
        scaled = total >>> cfg.shift;
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > acc_t'(PIX_MAX)) begin
            clamped = pixel_t'(PIX_MAX);
        end else begin
            clamped = scaled[PIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            v1_q        <= 1'b0;
            l1_q        <= 1'b0;
            res_valid_o <= 1'b0;
            res_last_o  <= 1'b0;
        end else begin
            v1_q        <= win_valid_i;  // tracks the row PE stage
            l1_q        <= win_last_i;
            res_valid_o <= v1_q;
            res_last_o  <= l1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (v1_q) begin
            res_q <= clamped;
        end
    end

    assign res_o = res_q;

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (rst_i)
        res_last_o |-> res_valid_o
    ) else $error("res_last without res_valid");

endmodule

//--- rtl/conv_engine_top.sv
// 3x3 streaming convolution; raster pixels without back-pressure, results 3 cycles after each strobe
`timescale 1ns/100ps

module conv_engine_top import conv_pkg::*; #(
    parameter int IMG_W = 16,  // at least 4
    parameter int IMG_H = 12   // at least 3
) (
    input  logic                  clk,
    input  logic                  rst_i,

    // host register port
    input  logic                  cfg_we_i,
    input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
    output logic [CFG_DATA_W-1:0] cfg_rdata_o,

    // pixel stream in
    input  logic                  pix_valid_i,
    input  pixel_t                pix_i,

    // result stream out
    output logic                  busy_o,
    output pixel_t                res_o,
    output logic                  res_valid_o,
    output logic                  res_last_o
);

    window_t win;
    logic    win_valid;
    logic    win_last;

    conv_cfg_if cfg_bus ();

    conv_cfg_regs u_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg         (cfg_bus.regs)
    );

    conv_window #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_window (
        .clk         (clk),
        .rst_i       (rst_i),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .win_o       (win),
        .win_valid_o (win_valid),
        .win_last_o  (win_last),
        .cfg         (cfg_bus.win)
    );

    conv_mac_array u_mac (
        .clk         (clk),
        .rst_i       (rst_i),
        .win_i       (win),
        .win_valid_i (win_valid),
        .win_last_i  (win_last),
        .cfg         (cfg_bus.mac),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_last_o  (res_last_o)
    );

    assign busy_o = cfg_bus.busy;  // falls the cycle after the last result

endmodule

//--- verification/conv_tb.sv
// self-checking testbench for a 16x12 frame; frames go one at a time, each drained before the next
`timescale 1ns/100ps

module conv_tb import conv_pkg::*; ();

    localparam int W       = 16;
    localparam int H       = 12;
    localparam int NPIX    = W * H;
    localparam int TIMEOUT = 2000;  // cycles per wait
    localparam int SEED    = 35;

    logic                  clk;
    logic                  rst_i;
    logic                  cfg_we_i;
    logic [CFG_ADDR_W-1:0] cfg_addr_i;
    logic [CFG_DATA_W-1:0] cfg_wdata_i;
    logic [CFG_DATA_W-1:0] cfg_rdata_o;
    logic                  pix_valid_i;
    pixel_t                pix_i;
    logic                  busy_o;
    pixel_t                res_o;
    logic                  res_valid_o;
    logic                  res_last_o;

    // host-side copy of the frame and kernel
    pixel_t frame [NPIX];
    int     wt [KER_TAPS];
    int     bias;
    int     shift;
    string  cur_test;

    // owned by the result checker
    int res_idx      = 0;
    int res_total    = 0;
    int frames_seen  = 0;
    int chk_errs     = 0;
    int chk_count    = 0;
    int clamp_lo     = 0;
    int clamp_hi     = 0;
    bit last_pending = 1'b0;  // busy_o must drop on the next cycle

    // owned by the test sequence
    int seq_errs     = 0;
    int seq_count    = 0;
    int frames_sent  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_mark     = 0;

    conv_engine_top #(
        .IMG_W (W),
        .IMG_H (H)
    ) uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .busy_o      (busy_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_last_o  (res_last_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected output pixel at raster position pos, zero halo outside the frame
    function automatic int conv_ref(input int pos);
        int x;
        int y;
        int xx;
        int yy;
        int acc;
        x   = pos % W;
        y   = pos / W;
        acc = 0;
        for (int r = 0; r < KER_DIM; r++) begin
            for (int c = 0; c < KER_DIM; c++) begin
                yy = y + r - 1;
                xx = x + c - 1;
                if (yy >= 0 && yy < H && xx >= 0 && xx < W) begin
                    acc += int'(frame[yy*W + xx]) * wt[r*KER_DIM + c];
                end
            end
        end
        acc = (acc + bias) >>> shift;
        if (acc < 0) begin
            return 0;
        end
        if (acc > 255) begin
            return 255;  // upper clamp
        end
        return acc;
    endfunction

    // result checker, results expected in raster order
    always @(negedge clk) begin
        int exp_v;
        if (!rst_i && last_pending) begin
            last_pending = 1'b0;
            chk_count++;
            if (busy_o) begin
                chk_errs++;
                $display("%s: busy_o still high the cycle after the last result", cur_test);
            end
        end
        if (!rst_i && res_valid_o) begin
            exp_v = conv_ref(res_idx);
            chk_count++;
            if (int'(res_o) != exp_v) begin
                chk_errs++;
                $display("ERR %s pos %0d expected %0d actual %0d",
                         cur_test, res_idx, exp_v, res_o);
            end
            if (res_last_o != (res_idx == NPIX - 1)) begin
                chk_errs++;
                $display("%s: end of frame flag wrong at position %0d", cur_test, res_idx);
            end
            if (!busy_o) begin
                chk_errs++;
                $display("%s: busy_o low while result %0d is out", cur_test, res_idx);
            end
            if (exp_v == 0) begin
                clamp_lo++;
            end
            if (exp_v == 255) begin
                clamp_hi++;
            end
            res_total++;
            if (res_idx == NPIX - 1) begin
                res_idx      = 0;
                last_pending = 1'b1;
                frames_seen++;
            end else begin
                res_idx++;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
    endtask

    task automatic read_reg(input logic [CFG_ADDR_W-1:0] addr,
                            output logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_addr_i <= addr;
        @(negedge clk);
        data = cfg_rdata_o;  // combinational readback
    endtask

    task automatic check_reg(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] exp_v);
        logic [CFG_DATA_W-1:0] rd;
        read_reg(addr, rd);
        seq_count++;
        if (rd !== exp_v) begin
            seq_errs++;
            $display("ERR %s reg %0d expected %h actual %h", cur_test, addr, exp_v, rd);
        end
    endtask

    task automatic load_kernel();
        for (int i = 0; i < KER_TAPS; i++) begin
            write_reg(CFG_ADDR_W'(i), CFG_DATA_W'(wt[i]));
        end
        write_reg(REG_BIAS, CFG_DATA_W'(bias));
        write_reg(REG_SHIFT, CFG_DATA_W'(shift));
    endtask

    task automatic random_kernel(input int shift_max);
        for (int i = 0; i < KER_TAPS; i++) begin
            wt[i] = int'($urandom_range(0, 255)) - 128;
        end
        bias  = int'($urandom_range(0, 4000)) - 2000;
        shift = int'($urandom_range(0, shift_max));
    endtask

    task automatic send_frame(input bit gaps);
        int gap;
        for (int i = 0; i < NPIX; i++) begin
            gap = gaps ? int'($urandom_range(0, 2)) : 0;
            repeat (gap) begin
                @(posedge clk);
                pix_valid_i <= 1'b0;
            end
            @(posedge clk);
            pix_valid_i <= 1'b1;
            pix_i       <= frame[i];
        end
        @(posedge clk);
        pix_valid_i <= 1'b0;
        frames_sent++;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frames_seen < target && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (frames_seen < target) begin
            abort_run($sformatf("%s: no last result for frame %0d in time", cur_test, target));
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            abort_run($sformatf("%s: busy_o stayed high after the frame", cur_test));
        end
    endtask

    task automatic run_frame(input bit gaps);
        int target;
        target = frames_sent + 1;
        @(negedge clk);
        seq_count++;
        if (busy_o) begin
            seq_errs++;
            $display("%s: busy_o high before the first pixel", cur_test);
        end
        send_frame(gaps);
        wait_frames(target);
        wait_idle();
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = chk_errs + seq_errs;
    endtask

    task automatic end_test();
        int errs;
        errs = chk_errs + seq_errs - err_mark;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", cur_test, (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial begin
        int lo_mark;
        int hi_mark;
        void'($urandom(SEED));
        rst_i       = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        pix_valid_i = 1'b0;
        pix_i       = '0;
        cur_test    = "reset";
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        begin_test("regs");
        check_reg(REG_FRAMES, '0);
        random_kernel(7);
        bias  = -int'($urandom_range(1, 30000));
        shift = int'($urandom_range(0, 31));
        load_kernel();
        for (int i = 0; i < KER_TAPS; i++) begin
            check_reg(CFG_ADDR_W'(i), CFG_DATA_W'(wt[i]));  // sign-extended weight
        end
        check_reg(REG_BIAS, CFG_DATA_W'(bias));
        check_reg(REG_SHIFT, CFG_DATA_W'(shift));
        for (int a = REG_FRAMES + 1; a < (1 << CFG_ADDR_W); a++) begin
            check_reg(CFG_ADDR_W'(a), '0);
        end
        end_test();

        begin_test("identity");
        for (int i = 0; i < KER_TAPS; i++) begin
            wt[i] = (i == KER_TAPS / 2) ? 1 : 0;
        end
        bias  = 0;
        shift = 0;
        load_kernel();
        for (int i = 0; i < NPIX; i++) begin
            frame[i] = pixel_t'($urandom_range(0, 255));
        end
        run_frame(1'b0);
        end_test();

        begin_test("halo");
        for (int i = 0; i < KER_TAPS; i++) begin
            wt[i] = 1;
        end
        load_kernel();
        for (int i = 0; i < NPIX; i++) begin
            frame[i] = 8'd10;  // 90 inside, 60 on edges, 40 in corners
        end
        run_frame(1'b0);
        seq_count++;
        if (res_total != NPIX * frames_sent) begin
            seq_errs++;
            $display("ERR %s result count expected %0d actual %0d",
                     cur_test, NPIX * frames_sent, res_total);
        end
        end_test();

        begin_test("random");
        lo_mark = clamp_lo;
        hi_mark = clamp_hi;
        for (int f = 0; f < 3; f++) begin
            random_kernel(7);
            load_kernel();
            for (int i = 0; i < NPIX; i++) begin
                frame[i] = pixel_t'($urandom_range(0, 255));
            end
            run_frame(1'b1);
        end
        seq_count++;
        if (clamp_lo == lo_mark || clamp_hi == hi_mark) begin
            seq_errs++;
            $display("%s: random frames did not reach both clamp limits", cur_test);
        end
        end_test();

        begin_test("status");
        random_kernel(4);
        load_kernel();
        run_frame(1'b1);
        check_reg(REG_FRAMES, CFG_DATA_W'(frames_sent));
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, chk_count + seq_count, chk_errs + seq_errs);
        if (tests_failed == 0 && chk_errs + seq_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/conv_pkg.sv
rtl/conv_cfg_if.sv
rtl/conv_cfg_regs.sv
rtl/conv_window.sv
rtl/conv_row_pe.sv
rtl/conv_mac_array.sv
rtl/conv_engine_top.sv
verification/conv_tb.sv

//--- Makefile
# Verilator build and run for the 3x3 convolution engine

VERILATOR ?= verilator
TOP       ?= conv_tb
RTL_TOP   ?= conv_engine_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the testbench prints its pass message
run: build
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
